/* src/exec_settings.svh */
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Datapath width
`define EXEC_DATA_W 16

// Rotate and shift count, low bits of operand B
`define EXEC_SHAMT_W 4

// Immediate fields of the I1 and I2 formats
`define EXEC_IMM5_W 5
`define EXEC_IMM8_W 8

`endif

/* src/isa_pkg.sv */
`include "exec_settings.svh"

package isa_pkg;

	typedef enum logic [4:0] {
		OP_ADDI  = 5'b01000,
		OP_SUBI  = 5'b01001,
		OP_XORI  = 5'b01010,
		OP_ANDNI = 5'b01011,
		OP_ST    = 5'b10000,
		OP_LD    = 5'b10001,
		OP_SLBI  = 5'b10010,
		OP_STU   = 5'b10011,
		OP_ROLI  = 5'b10100,
		OP_SLLI  = 5'b10101,
		OP_RORI  = 5'b10110,
		OP_SRLI  = 5'b10111,
		OP_LBI   = 5'b11000,
		OP_BTR   = 5'b11001,
		// Register shifts and rotates, picked by func
		OP_SHIFT = 5'b11010,
		// Register arithmetic and logic, picked by func
		OP_ARITH = 5'b11011,
		OP_SEQ   = 5'b11100,
		OP_SLT   = 5'b11101,
		OP_SLE   = 5'b11110,
		OP_SCO   = 5'b11111
	} opcode_e;

	// Same func value means one thing under OP_ARITH and another under OP_SHIFT
	typedef enum logic [1:0] {
		FN_ADD_ROL  = 2'b00,
		FN_SUB_SLL  = 2'b01,
		FN_XOR_ROR  = 2'b10,
		FN_ANDN_SRL = 2'b11
	} func_e;

	typedef struct packed {
		opcode_e    opcode;
		logic [2:0] rs;
		logic [2:0] rt;
		logic [2:0] rd;
		func_e      func;
	} r_format_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [2:0]              rs;
		logic [2:0]              rd;
		logic [`EXEC_IMM5_W-1:0] imm5;
	} i1_format_t;

	typedef struct packed {
		opcode_e                 opcode;
		logic [2:0]              rs;
		logic [`EXEC_IMM8_W-1:0] imm8;
	} i2_format_t;

	typedef union packed {
		r_format_t  r;
		i1_format_t i1;
		i2_format_t i2;
	} instr_word_u;

endpackage

/* src/exec_pkg.sv */
`include "exec_settings.svh"

package exec_pkg;

	typedef enum logic [3:0] {
		ALU_ROL  = 4'b0000,
		ALU_SLL  = 4'b0001,
		ALU_ROR  = 4'b0010,
		ALU_SRL  = 4'b0011,
		ALU_ADD  = 4'b0100,
		ALU_OR   = 4'b0101,
		ALU_XOR  = 4'b0110,
		ALU_AND  = 4'b0111,
		ALU_BTR  = 4'b1000,
		ALU_LBI  = 4'b1001,
		ALU_SLBI = 4'b1010,
		ALU_PASS = 4'b1111
	} alu_op_e;

	typedef enum logic [2:0] {
		SET_NONE = 3'd0,
		SET_EQ   = 3'd1,
		SET_LT   = 3'd2,
		SET_LE   = 3'd3,
		SET_CO   = 3'd4
	} set_sel_e;

	// Operand B source
	localparam logic SRC_REG = 1'b0;
	localparam logic SRC_IMM = 1'b1;

	typedef struct packed {
		alu_op_e  op;
		logic     inv_a;
		logic     inv_b;
		logic     cin;
		logic     sign;
		logic     alu_src;
		set_sel_e set_sel;
	} alu_ctrl_t;

	typedef struct packed {
		logic                    valid;
		isa_pkg::instr_word_u    instr;
		logic [`EXEC_DATA_W-1:0] rs_data;
		logic [`EXEC_DATA_W-1:0] rt_data;
	} exec_req_t;

	typedef struct packed {
		logic                    valid;
		logic [`EXEC_DATA_W-1:0] data;
	} exec_result_t;

endpackage

/* src/alu_control.sv */
module alu_control (
	input  isa_pkg::opcode_e    opcode,
	input  isa_pkg::func_e      func,
	output exec_pkg::alu_ctrl_t ctrl
);

	always_comb
	begin
		// Signed pass of Rs unless the opcode says otherwise
		ctrl.op      = exec_pkg::ALU_PASS;
		ctrl.inv_a   = 1'b0;
		ctrl.inv_b   = 1'b0;
		ctrl.cin     = 1'b0;
		ctrl.sign    = 1'b1;
		ctrl.alu_src = exec_pkg::SRC_REG;
		ctrl.set_sel = exec_pkg::SET_NONE;

		casez ({opcode, func})
			{isa_pkg::OP_ADDI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ADD;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			// imm - Rs
			{isa_pkg::OP_SUBI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ADD;
				ctrl.inv_a   = 1'b1;
				ctrl.cin     = 1'b1;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_XORI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_XOR;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_ANDNI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_AND;
				ctrl.inv_b   = 1'b1;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_ROLI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ROL;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_SLLI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_SLL;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_RORI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ROR;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_SRLI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_SRL;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_ARITH, isa_pkg::FN_ADD_ROL}: ctrl.op = exec_pkg::ALU_ADD;
			// Rt - Rs
			{isa_pkg::OP_ARITH, isa_pkg::FN_SUB_SLL}:
			begin
				ctrl.op    = exec_pkg::ALU_ADD;
				ctrl.inv_a = 1'b1;
				ctrl.cin   = 1'b1;
			end
			{isa_pkg::OP_ARITH, isa_pkg::FN_XOR_ROR}: ctrl.op = exec_pkg::ALU_XOR;
			{isa_pkg::OP_ARITH, isa_pkg::FN_ANDN_SRL}:
			begin
				ctrl.op    = exec_pkg::ALU_AND;
				ctrl.inv_b = 1'b1;
			end
			{isa_pkg::OP_SHIFT, isa_pkg::FN_ADD_ROL}: ctrl.op = exec_pkg::ALU_ROL;
			{isa_pkg::OP_SHIFT, isa_pkg::FN_SUB_SLL}: ctrl.op = exec_pkg::ALU_SLL;
			{isa_pkg::OP_SHIFT, isa_pkg::FN_XOR_ROR}: ctrl.op = exec_pkg::ALU_ROR;
			{isa_pkg::OP_SHIFT, isa_pkg::FN_ANDN_SRL}: ctrl.op = exec_pkg::ALU_SRL;
			{isa_pkg::OP_BTR, 2'b??}: ctrl.op = exec_pkg::ALU_BTR;
			// Compares all run Rs - Rt through the adder
			{isa_pkg::OP_SEQ, 2'b??}, {isa_pkg::OP_SLT, 2'b??}, {isa_pkg::OP_SLE, 2'b??}:
			begin
				ctrl.op    = exec_pkg::ALU_ADD;
				ctrl.inv_b = 1'b1;
				ctrl.cin   = 1'b1;
				if (opcode == isa_pkg::OP_SEQ)
					ctrl.set_sel = exec_pkg::SET_EQ;
				else if (opcode == isa_pkg::OP_SLT)
					ctrl.set_sel = exec_pkg::SET_LT;
				else
					ctrl.set_sel = exec_pkg::SET_LE;
			end
			{isa_pkg::OP_SCO, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ADD;
				ctrl.sign    = 1'b0;
				ctrl.set_sel = exec_pkg::SET_CO;
			end
			{isa_pkg::OP_LBI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_LBI;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			{isa_pkg::OP_SLBI, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_SLBI;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			// Address generation is unsigned
			{isa_pkg::OP_ST, 2'b??}, {isa_pkg::OP_LD, 2'b??}, {isa_pkg::OP_STU, 2'b??}:
			begin
				ctrl.op      = exec_pkg::ALU_ADD;
				ctrl.sign    = 1'b0;
				ctrl.alu_src = exec_pkg::SRC_IMM;
			end
			default: ctrl.op = exec_pkg::ALU_PASS;
		endcase
	end

endmodule

/* src/immediate_extend.sv */
`include "exec_settings.svh"

module immediate_extend (
	input  isa_pkg::instr_word_u    instr,
	output logic [`EXEC_DATA_W-1:0] imm
);

	localparam int W = `EXEC_DATA_W;

	isa_pkg::opcode_e opcode;
	logic use_imm8;
	logic zero_ext;
	logic fill5;
	logic fill8;

	// Opcode sits in the same bits in every format
	assign opcode = instr.i1.opcode;

	// LBI and SLBI are the I2 format users
	assign use_imm8 = (opcode == isa_pkg::OP_LBI) || (opcode == isa_pkg::OP_SLBI);

	// Logic immediates and the SLBI low byte are unsigned
	assign zero_ext = (opcode == isa_pkg::OP_XORI) ||
	                  (opcode == isa_pkg::OP_ANDNI) ||
	                  (opcode == isa_pkg::OP_SLBI);

	assign fill5 = ~zero_ext & instr.i1.imm5[`EXEC_IMM5_W-1];
	assign fill8 = ~zero_ext & instr.i2.imm8[`EXEC_IMM8_W-1];

	assign imm = use_imm8 ? {{(W-`EXEC_IMM8_W){fill8}}, instr.i2.imm8}
	                      : {{(W-`EXEC_IMM5_W){fill5}}, instr.i1.imm5};

endmodule

/* src/alu.sv */
`include "exec_settings.svh"

module alu (
	input  logic [`EXEC_DATA_W-1:0] a,
	input  logic [`EXEC_DATA_W-1:0] b,
	input  exec_pkg::alu_ctrl_t     ctrl,
	output logic [`EXEC_DATA_W-1:0] data
);

	localparam int W = `EXEC_DATA_W;

	logic [W-1:0] a_eff;
	logic [W-1:0] b_eff;
	logic [W-1:0] sum;
	logic [W-1:0] reversed;
	logic [W-1:0] result;
	logic [2*W-1:0] rol_wide;
	logic [2*W-1:0] ror_wide;
	logic [`EXEC_SHAMT_W-1:0] shamt;
	logic carry;
	logic overflow;
	logic zero;
	logic less;

	assign a_eff = ctrl.inv_a ? ~a : a;
	assign b_eff = ctrl.inv_b ? ~b : b;
	assign shamt = b_eff[`EXEC_SHAMT_W-1:0];

	assign {carry, sum} = {1'b0, a_eff} + {1'b0, b_eff} + {{W{1'b0}}, ctrl.cin};

	// Signed overflow when both inputs agree in sign and the sum does not
	assign overflow = (a_eff[W-1] == b_eff[W-1]) && (sum[W-1] != a_eff[W-1]);
	assign zero     = (sum == '0);
	assign less     = sum[W-1] ^ overflow;

	// Doubled word makes rotates a plain shift
	assign rol_wide = {a_eff, a_eff} << shamt;
	assign ror_wide = {a_eff, a_eff} >> shamt;

	always_comb
	begin
		for (int i = 0; i < W; i++)
		begin
			reversed[i] = a_eff[W-1-i];
		end
	end

	always_comb
	begin
		case (ctrl.op)
			exec_pkg::ALU_ROL:  result = rol_wide[2*W-1:W];
			exec_pkg::ALU_SLL:  result = a_eff << shamt;
			exec_pkg::ALU_ROR:  result = ror_wide[W-1:0];
			exec_pkg::ALU_SRL:  result = a_eff >> shamt;
			exec_pkg::ALU_ADD:  result = sum;
			exec_pkg::ALU_OR:   result = a_eff | b_eff;
			exec_pkg::ALU_XOR:  result = a_eff ^ b_eff;
			exec_pkg::ALU_AND:  result = a_eff & b_eff;
			exec_pkg::ALU_BTR:  result = reversed;
			exec_pkg::ALU_LBI:  result = b_eff;
			// Rs moves up a byte to take the new low byte
			exec_pkg::ALU_SLBI: result = (a_eff << `EXEC_IMM8_W) | b_eff;
			default:            result = a_eff;
		endcase
	end

	always_comb
	begin
		case (ctrl.set_sel)
			exec_pkg::SET_EQ: data = W'(zero);
			exec_pkg::SET_LT: data = W'(less);
			exec_pkg::SET_LE: data = W'(less | zero);
			exec_pkg::SET_CO: data = W'(carry);
			default:          data = result;
		endcase
	end

endmodule

/* src/execute_stage.sv */
`include "exec_settings.svh"

module execute_stage (
	input  logic                   clk,
	input  logic                   reset,
	input  exec_pkg::exec_req_t    req,
	output exec_pkg::exec_result_t rsp
);

	exec_pkg::alu_ctrl_t ctrl;
	logic [`EXEC_DATA_W-1:0] imm;
	logic [`EXEC_DATA_W-1:0] operand_b;
	logic [`EXEC_DATA_W-1:0] alu_data;

	alu_control u_alu_control (
		.opcode (req.instr.r.opcode),
		.func   (req.instr.r.func),
		.ctrl   (ctrl)
	);

	immediate_extend u_immediate_extend (
		.instr (req.instr),
		.imm   (imm)
	);

	// Operand B from Rt or the extended immediate
	assign operand_b = (ctrl.alu_src == exec_pkg::SRC_IMM) ? imm : req.rt_data;

	alu u_alu (
		.a    (req.rs_data),
		.b    (operand_b),
		.ctrl (ctrl),
		.data (alu_data)
	);

	// One result register, a new item every cycle
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rsp <= '0;
		end
		else
		begin
			rsp.valid <= req.valid;
			rsp.data  <= alu_data;
		end
	end

endmodule

/* sim/tb_clock.sv */
module tb_clock (
	output logic clk,
	output logic reset
);

	initial
	begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Held over three rising edges, released right after the third
	initial
	begin
		reset = 1'b1;
		repeat (3) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

/* sim/execute_properties.sv */
`include "exec_settings.svh"

module execute_properties (
	input logic                   clk,
	input logic                   reset,
	input exec_pkg::exec_req_t    req,
	input exec_pkg::exec_result_t rsp
);

	logic set_request;

	assign set_request = req.valid && (req.instr.r.opcode inside {isa_pkg::OP_SEQ,
		isa_pkg::OP_SLT, isa_pkg::OP_SLE, isa_pkg::OP_SCO});

	reset_clears_valid: assert property (@(posedge clk) reset |=> !rsp.valid)
		else $error("rsp.valid high in the cycle after reset");

	valid_follows_request: assert property (@(posedge clk) disable iff (reset)
		1'b1 |=> (rsp.valid == $past(req.valid)))
		else $error("rsp.valid does not follow req.valid by one cycle");

	// Compares yield only 0 or 1
	set_result_single_bit: assert property (@(posedge clk) disable iff (reset)
		set_request |=> (rsp.data[`EXEC_DATA_W-1:1] == '0))
		else $error("Set-condition result has upper bits set");

endmodule

bind execute_stage execute_properties u_execute_properties (
	.clk   (clk),
	.reset (reset),
	.req   (req),
	.rsp   (rsp)
);

/* sim/tb_execute_stage.sv */
module tb_execute_stage;

	localparam int TIMEOUT_CYCLES = 20;

	typedef struct packed {
		logic [15:0] instr;
		logic [15:0] rs_data;
		logic [15:0] rt_data;
		logic [15:0] expected;
	} vector_t;

	logic clk;
	logic reset;
	exec_pkg::exec_req_t req;
	exec_pkg::exec_result_t rsp;
	vector_t vectors[$];
	string names[$];
	logic [31:0] lcg_state;
	int pass_count;
	int fail_count;

	tb_clock u_clock (.clk(clk), .reset(reset));

	execute_stage uut (.clk(clk), .reset(reset), .req(req), .rsp(rsp));

	function automatic logic [31:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	function automatic isa_pkg::instr_word_u r_word(isa_pkg::opcode_e op, isa_pkg::func_e fn);
		isa_pkg::instr_word_u w;
		w = '0;
		w.r.opcode = op;
		w.r.func = fn;
		return w;
	endfunction

	function automatic isa_pkg::instr_word_u i1_word(isa_pkg::opcode_e op, logic [4:0] imm5);
		isa_pkg::instr_word_u w;
		w = '0;
		w.i1.opcode = op;
		w.i1.imm5 = imm5;
		return w;
	endfunction

	function automatic isa_pkg::instr_word_u i2_word(isa_pkg::opcode_e op, logic [7:0] imm8);
		isa_pkg::instr_word_u w;
		w = '0;
		w.i2.opcode = op;
		w.i2.imm8 = imm8;
		return w;
	endfunction

	task automatic add_vector(input string name, input isa_pkg::instr_word_u w,
		input logic [15:0] rs, input logic [15:0] rt, input logic [15:0] expected);
		vectors.push_back({w, rs, rt, expected});
		names.push_back(name);
	endtask

	task automatic report_test(input string name, input logic ok);
		if (ok)
		begin
			pass_count++;
			$display("PASS %s", name);
		end
		else
		begin
			fail_count++;
			$display("FAIL %s", name);
		end
	endtask

	task automatic check_reset();
		int cycles;
		logic ok;
		ok = 1'b1;
		cycles = 0;
		while (reset && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			cycles++;
		end
		if (reset)
		begin
			$display("Reset never released");
			ok = 1'b0;
		end
		if (rsp !== '0)
		begin
			$display("MISMATCH at %0t: rsp expected %h got %h", $time, 17'h0, rsp);
			ok = 1'b0;
		end
		repeat (2)
		begin
			@(negedge clk);
			if (rsp.valid !== 1'b0)
			begin
				$display("MISMATCH at %0t: rsp.valid expected 0 got %b", $time, rsp.valid);
				ok = 1'b0;
			end
		end
		report_test("reset", ok);
	endtask

	task automatic run_single(input vector_t v, input string name);
		int cycles;
		logic got;
		logic ok;
		ok = 1'b1;
		got = 1'b0;
		cycles = 0;
		@(negedge clk);
		req.valid = 1'b1;
		req.instr = v.instr;
		req.rs_data = v.rs_data;
		req.rt_data = v.rt_data;
		while (!got && cycles < TIMEOUT_CYCLES)
		begin
			@(negedge clk);
			req.valid = 1'b0;
			cycles++;
			got = rsp.valid;
		end
		if (!got)
		begin
			$display("No valid result for %s before the timeout", name);
			ok = 1'b0;
		end
		else
		begin
			if (cycles != 1)
			begin
				$display("Result for %s came after %0d cycles instead of one", name, cycles);
				ok = 1'b0;
			end
			if (rsp.data !== v.expected)
			begin
				$display("MISMATCH at %0t: rsp.data expected %h got %h", $time, v.expected,
					rsp.data);
				ok = 1'b0;
			end
			@(negedge clk);
			if (rsp.valid !== 1'b0)
			begin
				$display("Result for %s stayed valid longer than one cycle", name);
				ok = 1'b0;
			end
		end
		report_test(name, ok);
	endtask

	// Back-to-back requests with each result checked one cycle later
	task automatic run_random_burst(input int count);
		logic [31:0] r;
		logic [15:0] rs;
		logic [15:0] rt;
		logic [15:0] expected_prev;
		logic [1:0] sel;
		logic have_prev;
		logic ok;
		ok = 1'b1;
		have_prev = 1'b0;
		expected_prev = '0;
		for (int i = 0; i <= count; i++)
		begin
			@(negedge clk);
			if (have_prev && rsp.valid !== 1'b1)
			begin
				$display("Random result %0d missing in back-to-back stream", i - 1);
				ok = 1'b0;
			end
			else if (have_prev && rsp.data !== expected_prev)
			begin
				$display("MISMATCH at %0t: rsp.data expected %h got %h", $time, expected_prev,
					rsp.data);
				ok = 1'b0;
			end
			if (i < count)
			begin
				r = next_rand();
				rs = r[31:16];
				r = next_rand();
				rt = r[31:16];
				r = next_rand();
				sel = r[31:30];
				case (sel)
					2'd0: expected_prev = rs + rt;
					2'd1: expected_prev = rt - rs;
					2'd2: expected_prev = rs ^ rt;
					default: expected_prev = rs & ~rt;
				endcase
				req.valid = 1'b1;
				req.instr = r_word(isa_pkg::OP_ARITH, isa_pkg::func_e'(sel));
				req.rs_data = rs;
				req.rt_data = rt;
				have_prev = 1'b1;
			end
			else
			begin
				req.valid = 1'b0;
			end
		end
		report_test($sformatf("random burst of %0d", count), ok);
	endtask

	initial
	begin
		req = '0;
		pass_count = 0;
		fail_count = 0;
		lcg_state = 32'he91c_584d;

		add_vector("ADD", r_word(isa_pkg::OP_ARITH, isa_pkg::FN_ADD_ROL),
			16'h1234, 16'h0FF0, 16'h2224);
		add_vector("ADD wrap", r_word(isa_pkg::OP_ARITH, isa_pkg::FN_ADD_ROL),
			16'hFFFF, 16'h0002, 16'h0001);
		add_vector("SUB", r_word(isa_pkg::OP_ARITH, isa_pkg::FN_SUB_SLL),
			16'h0010, 16'h0100, 16'h00F0);
		add_vector("ADDI -3", i1_word(isa_pkg::OP_ADDI, 5'h1D),
			16'h0100, 16'hFFFF, 16'h00FD);
		add_vector("SUBI 15", i1_word(isa_pkg::OP_SUBI, 5'h0F),
			16'h0005, 16'hFFFF, 16'h000A);
		add_vector("LD +4", i1_word(isa_pkg::OP_LD, 5'h04),
			16'h2000, 16'hFFFF, 16'h2004);
		add_vector("ST -2", i1_word(isa_pkg::OP_ST, 5'h1E),
			16'h2000, 16'hFFFF, 16'h1FFE);
		add_vector("STU -16", i1_word(isa_pkg::OP_STU, 5'h10),
			16'h0100, 16'hFFFF, 16'h00F0);
		add_vector("XOR", r_word(isa_pkg::OP_ARITH, isa_pkg::FN_XOR_ROR),
			16'hF0F0, 16'hFF00, 16'h0FF0);
		add_vector("ANDN", r_word(isa_pkg::OP_ARITH, isa_pkg::FN_ANDN_SRL),
			16'hF0F0, 16'hFF00, 16'h00F0);
		add_vector("XORI", i1_word(isa_pkg::OP_XORI, 5'h1F),
			16'hAAAA, 16'hFFFF, 16'hAAB5);
		add_vector("ANDNI", i1_word(isa_pkg::OP_ANDNI, 5'h10),
			16'hFFFF, 16'h0000, 16'hFFEF);
		add_vector("ROL 1", r_word(isa_pkg::OP_SHIFT, isa_pkg::FN_ADD_ROL),
			16'h8001, 16'h0001, 16'h0003);
		add_vector("SLL 15", r_word(isa_pkg::OP_SHIFT, isa_pkg::FN_SUB_SLL),
			16'h0003, 16'h000F, 16'h8000);
		add_vector("ROR 15", r_word(isa_pkg::OP_SHIFT, isa_pkg::FN_XOR_ROR),
			16'h8001, 16'h000F, 16'h0003);
		add_vector("SRL 4", r_word(isa_pkg::OP_SHIFT, isa_pkg::FN_ANDN_SRL),
			16'h8000, 16'h0014, 16'h0800);
		add_vector("ROLI 4", i1_word(isa_pkg::OP_ROLI, 5'h04),
			16'h1234, 16'hFFFF, 16'h2341);
		add_vector("SLLI 15", i1_word(isa_pkg::OP_SLLI, 5'h0F),
			16'hFFFF, 16'h0000, 16'h8000);
		add_vector("RORI 8", i1_word(isa_pkg::OP_RORI, 5'h08),
			16'h1234, 16'hFFFF, 16'h3412);
		add_vector("SRLI 15", i1_word(isa_pkg::OP_SRLI, 5'h0F),
			16'h8000, 16'hFFFF, 16'h0001);
		add_vector("SRLI 0", i1_word(isa_pkg::OP_SRLI, 5'h00),
			16'hABCD, 16'hFFFF, 16'hABCD);
		add_vector("BTR", r_word(isa_pkg::OP_BTR, isa_pkg::FN_ADD_ROL),
			16'h1234, 16'h0000, 16'h2C48);
		add_vector("SEQ equal", r_word(isa_pkg::OP_SEQ, isa_pkg::FN_ADD_ROL),
			16'h1234, 16'h1234, 16'h0001);
		add_vector("SEQ differ", r_word(isa_pkg::OP_SEQ, isa_pkg::FN_ADD_ROL),
			16'h1234, 16'h1235, 16'h0000);
		add_vector("SLT true", r_word(isa_pkg::OP_SLT, isa_pkg::FN_ADD_ROL),
			16'h8000, 16'h7FFF, 16'h0001);
		add_vector("SLT false", r_word(isa_pkg::OP_SLT, isa_pkg::FN_ADD_ROL),
			16'h7FFF, 16'h8000, 16'h0000);
		add_vector("SLE equal", r_word(isa_pkg::OP_SLE, isa_pkg::FN_ADD_ROL),
			16'h7FFF, 16'h7FFF, 16'h0001);
		add_vector("SLE less", r_word(isa_pkg::OP_SLE, isa_pkg::FN_ADD_ROL),
			16'h8000, 16'h7FFF, 16'h0001);
		add_vector("SLE false", r_word(isa_pkg::OP_SLE, isa_pkg::FN_ADD_ROL),
			16'h7FFF, 16'h8000, 16'h0000);
		add_vector("SCO carry", r_word(isa_pkg::OP_SCO, isa_pkg::FN_ADD_ROL),
			16'hFFFF, 16'h0001, 16'h0001);
		add_vector("SCO none", r_word(isa_pkg::OP_SCO, isa_pkg::FN_ADD_ROL),
			16'h7FFF, 16'h0001, 16'h0000);
		add_vector("LBI", i2_word(isa_pkg::OP_LBI, 8'h80),
			16'h1234, 16'h0000, 16'hFF80);
		add_vector("SLBI", i2_word(isa_pkg::OP_SLBI, 8'h9C),
			16'hAB12, 16'h0000, 16'h129C);
		add_vector("unlisted", 16'h0123, 16'hBEEF, 16'h1111, 16'hBEEF);

		check_reset();
		foreach (vectors[i])
		begin
			run_single(vectors[i], names[i]);
		end
		run_random_burst(64);

		$display("Tests: %0d, passed: %0d, failed: %0d", pass_count + fail_count, pass_count,
			fail_count);
		if (fail_count == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

/* src.f */
+incdir+src
src/isa_pkg.sv
src/exec_pkg.sv
src/alu_control.sv
src/immediate_extend.sv
src/alu.sv
src/execute_stage.sv
sim/tb_clock.sv
sim/execute_properties.sv
sim/tb_execute_stage.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_execute_stage \
	-f src.f --Mdir obj_dir -o sim_execute_stage

output=$(./obj_dir/sim_execute_stage 2>&1) || { echo "$output"; exit 1; }
echo "$output"

echo "$output" | grep -qx "Everything OK"
